//--- include/nn_weights.svh
`ifndef NN_WEIGHTS_SVH
`define NN_WEIGHTS_SVH

// one row of fifteen weights per neuron, indexed [node][feature]
localparam float_t WEIGHTS [NODES][FEATURES] = '{
	// node 0
	'{
		32'h3EFBAA7A, 32'hBE8FC30B, 32'h3EAB63A9, 32'h3E788036, 32'h3EA049A7,
		32'h3E7BAC12, 32'hBE0CC2F3, 32'h3DA0B9EC, 32'hBF017AD2, 32'hBF1F348B,
		32'hBED3C8B4, 32'hBF23F2D9, 32'h3E82B821, 32'h3ECE73C2, 32'h3E384F85
	},
	// node 1, roughly 0.2 -0.35 0.55 -0.05 0.3 -0.5 0.1 0.45 ...
	'{
		32'h3E4CCCCD, 32'hBEB33333, 32'h3F0CCCCD, 32'hBD4CCCCD, 32'h3E99999A,
		32'hBF000000, 32'h3DCCCCCD, 32'h3EE66666, 32'hBE19999A, 32'h3F19999A,
		32'hBE800000, 32'h3D23D70A, 32'hBECCCCCD, 32'h3E000000, 32'hBF333333
	},
	// node 2 leans on the second and eighth features
	'{
		32'hBE4CCCCD, 32'h3F266666, 32'hBDCCCCCD, 32'h3EB33333, 32'hBF0CCCCD,
		32'h3E800000, 32'hBE99999A, 32'h3F400000, 32'hBD4CCCCD, 32'h3E19999A,
		32'hBF19999A, 32'h3ECCCCCD, 32'h3C23D70A, 32'hBEE66666, 32'h3F000000
	}
};

`endif

//--- verilog/nn_pkg.sv
package nn_pkg;

	// IEEE-754 single precision word and its fields
	typedef logic [31:0] float_t;
	typedef logic [7:0] exp_t;
	typedef logic [22:0] frac_t;

	// fraction with the hidden bit in front
	typedef logic [23:0] mant_t;

	// holds credit counts from zero up to four
	typedef logic [2:0] credit_cnt_t;

	localparam int FEATURES = 15;
	localparam int NODES = 3;

	localparam int IN_DEPTH = 4;
	localparam int IN_PTR_W = $clog2(IN_DEPTH);
	localparam int OUT_CREDITS = 4;

	// multiply register plus four adder tree levels
	localparam int PIPE_LATENCY = 5;

	localparam int EXP_BIAS = 127;

	`include "nn_weights.svh"

	function automatic exp_t fp_exp(input float_t x);
		return x[30:23];
	endfunction

	// subnormals are flushed, so a zero exponent gives a zero mantissa
	function automatic mant_t fp_mant(input float_t x);
		mant_t m;
		if (x[30:23] == '0)
			m = '0;
		else
			m = {1'b1, x[22:0]};
		return m;
	endfunction

	function automatic float_t fp_pack(input logic sign, input exp_t exp, input frac_t frac);
		return {sign, exp, frac};
	endfunction

endpackage

//--- verilog/fp_mult.sv
module fp_mult (
	input nn_pkg::float_t a,
	input nn_pkg::float_t b,
	output nn_pkg::float_t product
);
	import nn_pkg::*;

	logic [47:0] mant_prod;
	frac_t frac;
	int exp_sum;

	always_comb
	begin
		mant_prod = fp_mant(a) * fp_mant(b);

		// two mantissas in [1, 2) give a product in [1, 4), so one shift at most
		if (mant_prod[47])
		begin
			frac = mant_prod[46:24];
			exp_sum = int'(fp_exp(a)) + int'(fp_exp(b)) - EXP_BIAS + 1;
		end
		else
		begin
			frac = mant_prod[45:23];
			exp_sum = int'(fp_exp(a)) + int'(fp_exp(b)) - EXP_BIAS;
		end

		// zero, subnormal or underflowing operands all end up as positive zero
		if (fp_exp(a) == '0 || fp_exp(b) == '0 || exp_sum <= 0)
			product = '0;
		else
			product = fp_pack(a[31] ^ b[31], exp_t'(exp_sum), frac);
	end

endmodule

//--- verilog/fp_add.sv
module fp_add (
	input nn_pkg::float_t a,
	input nn_pkg::float_t b,
	output nn_pkg::float_t sum
);
	import nn_pkg::*;

	float_t op_big;
	float_t op_small;
	exp_t exp_diff;
	mant_t mant_big;
	mant_t mant_small;
	logic [24:0] mant_sum;
	mant_t mant_norm;
	logic [4:0] lead_zeros;
	int exp_norm;

	// the operand with the larger magnitude fixes sign and exponent
	always_comb
	begin
		if (a[30:0] >= b[30:0])
		begin
			op_big = a;
			op_small = b;
		end
		else
		begin
			op_big = b;
			op_small = a;
		end

		exp_diff = fp_exp(op_big) - fp_exp(op_small);
		mant_big = fp_mant(op_big);
		// bits shifted out on the right are simply lost
		mant_small = fp_mant(op_small) >> exp_diff;

		if (op_big[31] == op_small[31])
			mant_sum = {1'b0, mant_big} + {1'b0, mant_small};
		else
			mant_sum = {1'b0, mant_big} - {1'b0, mant_small};
	end

	always_comb
	begin
		lead_zeros = 5'd24;
		for (int i = 0; i < 24; i++)
		begin
			if (mant_sum[i])
				lead_zeros = 5'(23 - i);
		end

		if (mant_sum[24])
		begin
			mant_norm = mant_sum[24:1];
			exp_norm = int'(fp_exp(op_big)) + 1;
		end
		else
		begin
			mant_norm = mant_sum[23:0] << lead_zeros;
			exp_norm = int'(fp_exp(op_big)) - int'(lead_zeros);
		end

		// exact cancellation and underflow both give positive zero
		if (mant_sum == '0 || exp_norm <= 0)
			sum = '0;
		else
			sum = fp_pack(op_big[31], exp_t'(exp_norm), mant_norm[22:0]);
	end

endmodule

//--- verilog/neuron_pipe.sv
module neuron_pipe #(
	parameter int NODE = 0
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input nn_pkg::float_t issue_features [nn_pkg::FEATURES],
	output logic result_valid,
	output nn_pkg::float_t result
);
	import nn_pkg::*;

	float_t prod_d [FEATURES];
	float_t prod_q [FEATURES];

	// the tree is sized for fifteen products, 15 to 8 to 4 to 2 to 1
	float_t lvl1_d [7];
	float_t lvl1_q [8];
	float_t lvl2_d [4];
	float_t lvl2_q [4];
	float_t lvl3_d [2];
	float_t lvl3_q [2];
	float_t lvl4_d;

	logic [PIPE_LATENCY-1:0] valid_q;

	genvar i;

	for (i = 0; i < FEATURES; i++)
	begin : g_mult
		fp_mult mult_i (
			.a(issue_features[i]),
			.b(WEIGHTS[NODE][i]),
			.product(prod_d[i])
		);
	end

	for (i = 0; i < 7; i++)
	begin : g_lvl1
		fp_add add_i (
			.a(prod_q[2*i]),
			.b(prod_q[2*i+1]),
			.sum(lvl1_d[i])
		);
	end

	// the odd product joins at level two, beside the pair 12 and 13
	for (i = 0; i < 4; i++)
	begin : g_lvl2
		fp_add add_i (
			.a(lvl1_q[2*i]),
			.b(lvl1_q[2*i+1]),
			.sum(lvl2_d[i])
		);
	end

	for (i = 0; i < 2; i++)
	begin : g_lvl3
		fp_add add_i (
			.a(lvl2_q[2*i]),
			.b(lvl2_q[2*i+1]),
			.sum(lvl3_d[i])
		);
	end

	fp_add add_final (
		.a(lvl3_q[0]),
		.b(lvl3_q[1]),
		.sum(lvl4_d)
	);

	always_ff @(posedge clk)
	begin
		prod_q <= prod_d;
		for (int k = 0; k < 7; k++)
			lvl1_q[k] <= lvl1_d[k];
		lvl1_q[7] <= prod_q[14];
		lvl2_q <= lvl2_d;
		lvl3_q <= lvl3_d;
		// ReLU, any negative sum becomes zero
		result <= lvl4_d[31] ? '0 : lvl4_d;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= '0;
		else
			valid_q <= {valid_q[PIPE_LATENCY-2:0], issue_valid};
	end

	assign result_valid = valid_q[PIPE_LATENCY-1];

	// every issued sample comes out after the fixed pipeline depth
	assert property (@(posedge clk) disable iff (reset)
		issue_valid |-> ##PIPE_LATENCY result_valid);

endmodule

//--- verilog/sample_queue.sv
module sample_queue (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input nn_pkg::float_t in_features [nn_pkg::FEATURES],
	input logic out_credit,
	output logic in_credit,
	output logic issue_valid,
	output nn_pkg::float_t issue_features [nn_pkg::FEATURES]
);
	import nn_pkg::*;

	float_t mem [IN_DEPTH][FEATURES];

	// one extra pointer bit tells full from empty
	logic [IN_PTR_W:0] wr_ptr;
	logic [IN_PTR_W:0] rd_ptr;
	logic empty;
	logic full;
	logic pop;
	credit_cnt_t credits;

	assign empty = wr_ptr == rd_ptr;
	assign full = (wr_ptr[IN_PTR_W] != rd_ptr[IN_PTR_W]) &&
		(wr_ptr[IN_PTR_W-1:0] == rd_ptr[IN_PTR_W-1:0]);

	// a sample leaves only when its result slot is already paid for
	assign pop = !empty && credits != '0;
	assign issue_valid = pop;
	assign in_credit = pop;
	assign issue_features = mem[rd_ptr[IN_PTR_W-1:0]];

	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr[IN_PTR_W-1:0]] <= in_features;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			credits <= credit_cnt_t'(OUT_CREDITS);
		end
		else
		begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			credits <= credits - credit_cnt_t'(pop) + credit_cnt_t'(out_credit);
		end
	end

	// the producer must hold an input credit for every write
	assert property (@(posedge clk) disable iff (reset) in_valid |-> !full);

	// the consumer never returns more slots than it granted
	assert property (@(posedge clk) disable iff (reset) credits <= OUT_CREDITS);

endmodule

//--- verilog/nn_layer_top.sv
module nn_layer_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input nn_pkg::float_t in_features [nn_pkg::FEATURES],
	output logic in_credit,
	output logic out_valid,
	output nn_pkg::float_t out_result [nn_pkg::NODES],
	input logic out_credit
);
	import nn_pkg::*;

	logic issue_valid;
	float_t issue_features [FEATURES];
	logic [NODES-1:0] node_valid;

	sample_queue queue_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_features(in_features),
		.out_credit(out_credit),
		.in_credit(in_credit),
		.issue_valid(issue_valid),
		.issue_features(issue_features)
	);

	genvar n;

	// node n drives result word n
	for (n = 0; n < NODES; n++)
	begin : g_node
		neuron_pipe #(
			.NODE(n)
		) neuron_i (
			.clk(clk),
			.reset(reset),
			.issue_valid(issue_valid),
			.issue_features(issue_features),
			.result_valid(node_valid[n]),
			.result(out_result[n])
		);
	end

	// all neurons run on one schedule, so node 0 speaks for the layer
	assign out_valid = node_valid[0];

endmodule

//--- tb/nn_layer_tb.sv
module nn_layer_tb;
	import nn_pkg::*;

	localparam int MAX_SAMPLES = 64;
	// cycles that the consumer keeps its slots after a flagged result
	localparam int HOLD_CYCLES = 12;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	float_t in_features [FEATURES];
	logic in_credit;
	logic out_valid;
	float_t out_result [NODES];
	logic out_credit;

	float_t feat_mem [MAX_SAMPLES][FEATURES];
	float_t exp_mem [MAX_SAMPLES][NODES];
	logic [31:0] flag_mem [MAX_SAMPLES];
	int num_samples;

	int errors;
	int cycle_count;
	int cycle_limit;
	int sent_count;
	int credit_pulses;
	int rx_count;
	int credits_returned;
	int hold_timer;
	int after_reset;

	nn_layer_top dut_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_features(in_features),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_result(out_result),
		.out_credit(out_credit)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at time %0t: %s expected %h, got %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at time %0t: %s", $time, what);
	endtask

	task automatic print_counts();
		$display("samples: %0d, results: %0d, errors: %0d", num_samples, rx_count, errors);
	endtask

	task automatic load_stimulus();
		int fd;
		int code;
		string line;
		logic [31:0] word;
		fd = $fopen("tb/nn_stimulus.txt", "r");
		num_samples = 0;
		if (fd == 0)
		begin
			report_failure("cannot open the stimulus file");
			return;
		end
		// two header lines describe the columns
		code = $fgets(line, fd);
		code = $fgets(line, fd);
		while (num_samples < MAX_SAMPLES)
		begin
			code = $fscanf(fd, "%h", word);
			if (code != 1)
				break;
			feat_mem[num_samples][0] = word;
			for (int f = 1; f < FEATURES; f++)
			begin
				code = $fscanf(fd, "%h", word);
				feat_mem[num_samples][f] = word;
			end
			for (int n = 0; n < NODES; n++)
			begin
				code = $fscanf(fd, "%h", word);
				exp_mem[num_samples][n] = word;
			end
			code = $fscanf(fd, "%h", word);
			flag_mem[num_samples] = word;
			num_samples++;
		end
		$fclose(fd);
	endtask

	// producer side, one sample per cycle while an input credit is held
	always @(posedge clk)
	begin
		if (reset)
			in_valid <= 1'b0;
		else if (sent_count < num_samples && IN_DEPTH + credit_pulses - sent_count > 0)
		begin
			in_valid <= 1'b1;
			for (int f = 0; f < FEATURES; f++)
				in_features[f] <= feat_mem[sent_count][f];
			sent_count++;
		end
		else
			in_valid <= 1'b0;
	end

	// consumer side returns one slot per cycle unless it is holding them
	always @(posedge clk)
	begin
		if (reset)
			out_credit <= 1'b0;
		else if (rx_count > credits_returned && hold_timer == 0)
		begin
			out_credit <= 1'b1;
			credits_returned++;
		end
		else
			out_credit <= 1'b0;
	end

	// outputs are sampled on the falling edge, away from the driving edge
	always @(negedge clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			report_failure($sformatf("timeout after %0d cycles with %0d of %0d results received",
				cycle_count, rx_count, num_samples));
			print_counts();
			$display("test failed");
			$finish;
		end
		else
		begin
			if (hold_timer > 0)
				hold_timer--;

			if (reset || after_reset == 0)
			begin
				check_value("out_valid during reset", 32'd0, {31'd0, out_valid});
				check_value("in_credit during reset", 32'd0, {31'd0, in_credit});
			end
			if (!reset)
				after_reset++;

			if (!reset && in_credit)
			begin
				if (credit_pulses >= sent_count)
					report_failure("in_credit pulse with no sample outstanding");
				credit_pulses++;
			end

			if (!reset && out_valid)
			begin
				if (rx_count >= num_samples)
					report_failure("extra result after all samples were answered");
				else
				begin
					if (rx_count + 1 > OUT_CREDITS + credits_returned)
						report_failure("flow-control violation, results exceed credits");
					for (int n = 0; n < NODES; n++)
					begin
						check_value($sformatf("out_result[%0d] of sample %0d", n, rx_count),
							exp_mem[rx_count][n], out_result[n]);
						if (out_result[n][31])
							report_failure("ReLU output carries a negative sign");
					end
					if (flag_mem[rx_count] != 0)
						hold_timer = HOLD_CYCLES;
				end
				rx_count++;
			end
		end
	end

	initial
	begin
		errors = 0;
		cycle_count = 0;
		sent_count = 0;
		credit_pulses = 0;
		rx_count = 0;
		credits_returned = 0;
		hold_timer = 0;
		after_reset = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		out_credit = 1'b0;
		for (int f = 0; f < FEATURES; f++)
			in_features[f] = '0;
		load_stimulus();
		cycle_limit = num_samples * 20 + 100;

		repeat (2) @(posedge clk);
		reset <= 1'b0;

		while (rx_count < num_samples || num_samples == 0)
			@(negedge clk);
		// let late or extra results and credits show up
		repeat (10) @(negedge clk);

		if (rx_count != num_samples)
			report_failure("number of results differs from number of samples");
		check_value("in_credit pulse count", num_samples, credit_pulses);
		check_value("samples sent", num_samples, sent_count);

		print_counts();
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- tb/nn_stimulus.txt
# per line: 15 feature words, expected result of node 0 1 2, withhold flag
# words are hex IEEE-754 single precision, 0 stands for positive zero
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3F800000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3EFBAA7A 3E4CCCCD 0 0
0 3F800000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3F266666 0
0 0 BF800000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3DCCCCCD 0
0 0 0 40000000 0 0 0 0 0 0 0 0 0 0 0 3EF88036 0 3F333333 1
0 0 0 0 3F000000 0 0 0 0 0 0 0 0 0 0 3E2049A7 3E19999A 0 0
0 0 0 0 0 3F800000 0 0 0 0 0 0 0 0 0 3E7BAC12 0 3E800000 0
0 0 0 0 0 0 BF800000 0 0 0 0 0 0 0 0 3E0CC2F3 0 3E99999A 0
0 0 0 0 0 0 0 3F800000 0 0 0 0 0 0 0 3DA0B9EC 3EE66666 3F400000 0
0 0 0 0 0 0 0 0 C0000000 0 0 0 0 0 0 3F817AD2 3E99999A 3DCCCCCD 1
0 0 0 0 0 0 0 0 0 3F800000 0 0 0 0 0 0 3F19999A 3E19999A 0
0 0 0 0 0 0 0 0 0 0 BF000000 0 0 0 0 3E53C8B4 3E000000 3E99999A 0
0 0 0 0 0 0 0 0 0 0 0 3F800000 0 0 0 0 3D23D70A 3ECCCCCD 0
0 0 0 0 0 0 0 0 0 0 0 0 3F800000 0 0 3E82B821 0 3C23D70A 0
0 0 0 0 0 0 0 0 0 0 0 0 0 40000000 0 3F4E73C2 3E800000 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 3F800000 3E384F85 0 3F000000 0
0 BF800000 0 0 0 0 0 0 0 0 0 0 0 0 0 3E8FC30B 3EB33333 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- project.f
+incdir+include
verilog/nn_pkg.sv
verilog/fp_mult.sv
verilog/fp_add.sv
verilog/neuron_pipe.sv
verilog/sample_queue.sv
verilog/nn_layer_top.sv
tb/nn_layer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module nn_layer_tb -o nn_layer_sim || exit 1
./obj_dir/nn_layer_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log && exit 0 || exit 1
